/* hw/pit_pkg.sv */
// Interval timer package with control word layout, access and mode encodings, address map
package pit_pkg;

  // Number of timer channels, fixed by the 2-bit address map
  localparam int NUM_CH = 3;

  // Address 3 is the control word, 0..2 are the channel count ports
  localparam logic [1:0] ADDR_CTRL = 2'd3;

  // Read/write access format of a channel
  // Latch is only meaningful inside a control word
  typedef enum logic [1:0] {
    ACC_LATCH = 2'd0,
    ACC_LSB   = 2'd1,
    ACC_MSB   = 2'd2,
    ACC_BOTH  = 2'd3
  } pit_access_e;

  // Supported counting modes
  // Unsupported mode codes fall back to mode 0
  typedef enum logic [2:0] {
    MODE_0 = 3'd0,
    MODE_2 = 3'd2,
    MODE_3 = 3'd3
  } pit_mode_e;

  // Mode word view
  typedef struct packed {
    logic [1:0]  sel;
    pit_access_e access;
    logic [2:0]  mode;
    logic        bcd;
  } pit_mode_word_t;

  // Counter latch command view, cmd field is zero
  typedef struct packed {
    logic [1:0] sel;
    logic [1:0] cmd;
    logic [3:0] unused;
  } pit_latch_cmd_t;

  // One control byte, two decodes
  typedef union packed {
    pit_mode_word_t mode_word;
    pit_latch_cmd_t latch_cmd;
  } pit_ctrl_word_u;

endpackage

/* hw/pit_bus_port.sv */
// Timer bus port: request/response handshake, address decode and read data return
`timescale 1ns/10ps

module pit_bus_port
  import pit_pkg::*;
(
  input  logic                   WR_,
  input  logic                   LOAD,
  // Request channel
  input  logic                   req_valid,
  output logic                   req_ready,
  input  logic                   req_write,
  input  logic [1:0]             req_addr,
  input  logic [7:0]             req_wdata,
  // Read response channel
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output logic [7:0]             rsp_rdata,
  // Channel side
  output logic [7:0]             wdata,
  output logic [NUM_CH-1:0]      wr_stb,
  output logic [NUM_CH-1:0]      rd_stb,
  output logic [NUM_CH-1:0]      ctrl_stb,
  input  logic [NUM_CH-1:0][7:0] ch_rdata
);

  pit_ctrl_word_u ctrl_word;
  logic           req_fire;
  logic           rd_fire;

  // Only back-pressure is a pending read response
  assign req_ready = ~rsp_valid;
  assign req_fire  = req_valid & req_ready;
  assign rd_fire   = req_fire & ~req_write;

  // Write byte shared by all channels
  assign wdata     = req_wdata;
  // Select field sits in the same bits for both decodes
  assign ctrl_word = req_wdata;

  // Strobes straight from the accepted request
  always_comb begin
    wr_stb   = '0;
    rd_stb   = '0;
    ctrl_stb = '0;
    if (req_fire) begin
      if (req_addr == ADDR_CTRL) begin
        // Select value 3 addresses no channel
        if (req_write && (ctrl_word.mode_word.sel != 2'd3)) begin
          ctrl_stb[ctrl_word.mode_word.sel] = 1'b1;
        end
      end else if (req_write) begin
        wr_stb[req_addr] = 1'b1;
      end else begin
        rd_stb[req_addr] = 1'b1;
      end
    end
  end

  // Response pending flag
  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      rsp_valid <= 1'b0;
    end else if (rd_fire) begin
      rsp_valid <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid <= 1'b0;
    end
  end

  // Response data, held until taken
  // Control address reads back as zero
  always_ff @(posedge WR_) begin
    if (rd_fire) begin
      rsp_rdata <= (req_addr == ADDR_CTRL) ? 8'h00 : ch_rdata[req_addr];
    end
  end

endmodule

/* hw/pit_channel_regs.sv */
// Timer channel registers: control word decode, count write staging and count read latch
`timescale 1ns/10ps

module pit_channel_regs
  import pit_pkg::*;
(
  input  logic        WR_,
  input  logic        LOAD,
  input  logic [7:0]  wdata,
  input  logic        wr_stb,
  input  logic        rd_stb,
  input  logic        ctrl_stb,
  input  logic [15:0] count,
  output logic [7:0]  rdata,
  output pit_mode_e   mode,
  output logic [15:0] count_init,
  output logic        load_req,
  output logic        mode_set
);

  pit_ctrl_word_u ctrl;
  pit_access_e    access;
  logic           is_latch_cmd;
  // Byte pointers, high means next byte is the MSB
  logic           wr_msb;
  logic           rd_msb;
  logic           wr_last;
  logic           rd_last;
  // Read latch
  logic           latch_held;
  logic [15:0]    latch_val;
  logic [15:0]    rd_src;

  assign ctrl         = wdata;
  assign is_latch_cmd = (ctrl.latch_cmd.cmd == 2'b00);

  // Last byte of the access format
  assign wr_last = (access != ACC_BOTH) || wr_msb;
  assign rd_last = (access != ACC_BOTH) || rd_msb;

  // Latched value wins over the live count
  assign rd_src = latch_held ? latch_val : count;

  always_comb begin
    case (access)
      ACC_MSB:  rdata = rd_src[15:8];
      ACC_BOTH: rdata = rd_msb ? rd_src[15:8] : rd_src[7:0];
      default:  rdata = rd_src[7:0];
    endcase
  end

  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      access     <= ACC_LSB;
      mode       <= MODE_0;
      count_init <= '0;
      wr_msb     <= 1'b0;
      rd_msb     <= 1'b0;
      latch_held <= 1'b0;
      load_req   <= 1'b0;
      mode_set   <= 1'b0;
    end else begin
      // Both pulses last one cycle
      load_req <= 1'b0;
      mode_set <= 1'b0;

      if (ctrl_stb) begin
        if (is_latch_cmd) begin
          // A second latch before readout is ignored
          latch_held <= 1'b1;
        end else begin
          access <= ctrl.mode_word.access;
          case (ctrl.mode_word.mode)
            3'd2:    mode <= MODE_2;
            3'd3:    mode <= MODE_3;
            default: mode <= MODE_0;
          endcase
          count_init <= '0;
          wr_msb     <= 1'b0;
          rd_msb     <= 1'b0;
          mode_set   <= 1'b1;
        end
      end

      // Count byte writes
      if (wr_stb) begin
        if ((access == ACC_MSB) || ((access == ACC_BOTH) && wr_msb)) begin
          count_init[15:8] <= wdata;
        end else begin
          count_init[7:0] <= wdata;
        end
        if (access == ACC_BOTH) begin
          wr_msb <= ~wr_msb;
        end
        load_req <= wr_last;
      end

      // Count byte reads, latch released after the final byte
      if (rd_stb) begin
        if (access == ACC_BOTH) begin
          rd_msb <= ~rd_msb;
        end
        if (rd_last) begin
          latch_held <= 1'b0;
        end
      end
    end
  end

  // Count snapshot on the latch command edge
  always_ff @(posedge WR_) begin
    if (ctrl_stb && is_latch_cmd && !latch_held) begin
      latch_val <= count;
    end
  end

endmodule

/* hw/pit_channel_counter.sv */
// Timer channel counter: 16-bit down counter and output waveform for modes 0, 2 and 3
`timescale 1ns/10ps

module pit_channel_counter
  import pit_pkg::*;
(
  input  logic        WR_,
  input  logic        LOAD,
  input  logic        tick,
  input  logic        gate,
  input  pit_mode_e   mode,
  input  logic [15:0] count_init,
  input  logic        load_req,
  input  logic        mode_set,
  output logic [15:0] count,
  output logic        timer_out
);

  // Load requested, waiting for a tick
  logic        load_pend;
  // Count valid since last load
  logic        loaded;
  logic        load_now;
  logic        count_en;
  logic [15:0] reload_val;
  logic        out_idle;

  // Mode 3 drops the low bit of the count
  assign reload_val = (mode == MODE_3) ? {count_init[15:1], 1'b0} : count_init;

  // Load needs a tick only, gate is ignored
  assign load_now = (load_req | load_pend) & tick;
  assign count_en = loaded & tick & gate;

  // Output level after a mode write or a load
  assign out_idle = (mode != MODE_0);

  always_ff @(posedge WR_ or posedge LOAD) begin
    if (LOAD) begin
      load_pend <= 1'b0;
      loaded    <= 1'b0;
      count     <= '0;
      timer_out <= 1'b1;
    end else if (mode_set) begin
      // Stop until the next count load
      load_pend <= 1'b0;
      loaded    <= 1'b0;
      timer_out <= out_idle;
    end else if (load_now) begin
      load_pend <= 1'b0;
      loaded    <= 1'b1;
      count     <= reload_val;
      timer_out <= out_idle;
    end else begin
      if (load_req) begin
        load_pend <= 1'b1;
      end
      if (count_en) begin
        case (mode)
          MODE_2: begin
            // Low for the tick at count 1, reload after it
            if (count == 16'd1) begin
              count     <= reload_val;
              timer_out <= 1'b1;
            end else begin
              count     <= count - 16'd1;
              timer_out <= (count != 16'd2);
            end
          end
          MODE_3: begin
            // Half period ends when the count hits 0
            if (count == 16'd2) begin
              count     <= reload_val;
              timer_out <= ~timer_out;
            end else begin
              count <= count - 16'd2;
            end
          end
          default: begin
            // Terminal count, output stays high
            // Count wraps with no reload
            count <= count - 16'd1;
            if (count == 16'd1) begin
              timer_out <= 1'b1;
            end
          end
        endcase
      end
    end
  end

endmodule

/* hw/pit_top.sv */
// Programmable interval timer top: bus port plus three register and counter channel pairs
`timescale 1ns/10ps

module pit_top
  import pit_pkg::*;
(
  input  logic              WR_,
  input  logic              LOAD,
  // Request channel
  input  logic              req_valid,
  output logic              req_ready,
  input  logic              req_write,
  input  logic [1:0]        req_addr,
  input  logic [7:0]        req_wdata,
  // Read response channel
  output logic              rsp_valid,
  input  logic              rsp_ready,
  output logic [7:0]        rsp_rdata,
  // Per-channel tick, gate and output
  input  logic [NUM_CH-1:0] tick,
  input  logic [NUM_CH-1:0] gate,
  output logic [NUM_CH-1:0] timer_out
);

  logic [7:0]              wdata;
  logic [NUM_CH-1:0]       wr_stb;
  logic [NUM_CH-1:0]       rd_stb;
  logic [NUM_CH-1:0]       ctrl_stb;
  logic [NUM_CH-1:0][7:0]  ch_rdata;
  // Register block to counter
  pit_mode_e               ch_mode [NUM_CH];
  logic [NUM_CH-1:0][15:0] ch_count_init;
  logic [NUM_CH-1:0]       ch_load_req;
  logic [NUM_CH-1:0]       ch_mode_set;
  // Counter back to register block
  logic [NUM_CH-1:0][15:0] ch_count;

  pit_bus_port i_bus_port (
    .WR_       (WR_),
    .LOAD      (LOAD),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata),
    .wdata     (wdata),
    .wr_stb    (wr_stb),
    .rd_stb    (rd_stb),
    .ctrl_stb  (ctrl_stb),
    .ch_rdata  (ch_rdata)
  );

  // One register block beside each counter
  for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
    pit_channel_regs i_regs (
      .WR_        (WR_),
      .LOAD       (LOAD),
      .wdata      (wdata),
      .wr_stb     (wr_stb[ch]),
      .rd_stb     (rd_stb[ch]),
      .ctrl_stb   (ctrl_stb[ch]),
      .count      (ch_count[ch]),
      .rdata      (ch_rdata[ch]),
      .mode       (ch_mode[ch]),
      .count_init (ch_count_init[ch]),
      .load_req   (ch_load_req[ch]),
      .mode_set   (ch_mode_set[ch])
    );

    pit_channel_counter i_counter (
      .WR_        (WR_),
      .LOAD       (LOAD),
      .tick       (tick[ch]),
      .gate       (gate[ch]),
      .mode       (ch_mode[ch]),
      .count_init (ch_count_init[ch]),
      .load_req   (ch_load_req[ch]),
      .mode_set   (ch_mode_set[ch]),
      .count      (ch_count[ch]),
      .timer_out  (timer_out[ch])
    );
  end

endmodule

/* tb/pit_checker.sv */
// Interval timer checker holding a cycle model of the three channels and comparing outputs
`timescale 1ns/10ps

module pit_checker
  import pit_pkg::*;
(
  input  logic              WR_,
  input  logic              LOAD,
  input  logic              req_valid,
  input  logic              req_ready,
  input  logic              req_write,
  input  logic [1:0]        req_addr,
  input  logic [7:0]        req_wdata,
  input  logic              rsp_valid,
  input  logic              rsp_ready,
  input  logic [7:0]        rsp_rdata,
  input  logic [NUM_CH-1:0] tick,
  input  logic [NUM_CH-1:0] gate,
  input  logic [NUM_CH-1:0] timer_out,
  output int                error_count
);

  // Register side of each channel
  logic [1:0]  m_acc      [NUM_CH];
  logic [2:0]  m_mode     [NUM_CH];
  logic [15:0] m_init     [NUM_CH];
  logic        m_wr_msb   [NUM_CH];
  logic        m_rd_msb   [NUM_CH];
  logic        m_held     [NUM_CH];
  logic [15:0] m_latch    [NUM_CH];
  logic        m_load_req [NUM_CH];
  logic        m_mode_set [NUM_CH];
  // Counter side of each channel
  logic        m_pend     [NUM_CH];
  logic        m_loaded   [NUM_CH];
  logic [15:0] m_count    [NUM_CH];
  logic        m_out      [NUM_CH];
  // Pending read response
  logic        m_rsp_valid;
  logic [7:0]  m_rsp_data;

  task automatic reset_model();
    int c;
    for (c = 0; c < NUM_CH; c++) begin
      m_acc[c]      = ACC_LSB;
      m_mode[c]     = 3'd0;
      m_init[c]     = 16'h0000;
      m_wr_msb[c]   = 1'b0;
      m_rd_msb[c]   = 1'b0;
      m_held[c]     = 1'b0;
      m_load_req[c] = 1'b0;
      m_mode_set[c] = 1'b0;
      m_pend[c]     = 1'b0;
      m_loaded[c]   = 1'b0;
      m_count[c]    = 16'h0000;
      // Output idles high out of reset
      m_out[c]      = 1'b1;
    end
    m_rsp_valid = 1'b0;
  endtask

  // Byte a read returns from the latch if held or else from the live count
  function automatic logic [7:0] read_byte(input logic [1:0] c);
    logic [15:0] src;
    src = m_held[c] ? m_latch[c] : m_count[c];
    if ((m_acc[c] == ACC_MSB) || ((m_acc[c] == ACC_BOTH) && m_rd_msb[c])) begin
      return src[15:8];
    end
    return src[7:0];
  endfunction

  task automatic step_counter(input int c);
    logic [15:0] reload;
    // Square wave ignores the odd bit
    reload = (m_mode[c] == 3'd3) ? {m_init[c][15:1], 1'b0} : m_init[c];
    if (m_mode_set[c]) begin
      m_pend[c]   = 1'b0;
      m_loaded[c] = 1'b0;
      m_out[c]    = (m_mode[c] != 3'd0);
    end else if ((m_load_req[c] || m_pend[c]) && tick[c]) begin
      // Load waits for a tick and ignores gate
      m_pend[c]   = 1'b0;
      m_loaded[c] = 1'b1;
      m_count[c]  = reload;
      m_out[c]    = (m_mode[c] != 3'd0);
    end else begin
      if (m_load_req[c]) begin
        m_pend[c] = 1'b1;
      end
      if (m_loaded[c] && tick[c] && gate[c]) begin
        case (m_mode[c])
          3'd2: begin
            // Low only while sitting at 1
            if (m_count[c] == 16'd1) begin
              m_count[c] = reload;
              m_out[c]   = 1'b1;
            end else begin
              m_count[c] = m_count[c] - 16'd1;
              m_out[c]   = (m_count[c] != 16'd1);
            end
          end
          3'd3: begin
            m_count[c] = m_count[c] - 16'd2;
            // Half period done
            if (m_count[c] == 16'd0) begin
              m_out[c]   = ~m_out[c];
              m_count[c] = reload;
            end
          end
          default: begin
            // Terminal count sticks while the count wraps on
            m_count[c] = m_count[c] - 16'd1;
            if (m_count[c] == 16'd0) begin
              m_out[c] = 1'b1;
            end
          end
        endcase
      end
    end
  endtask

  task automatic step_regs(input int c, input logic wr, input logic rd, input logic ctrl,
                           input logic [15:0] old_count);
    m_load_req[c] = 1'b0;
    m_mode_set[c] = 1'b0;
    if (ctrl) begin
      if (req_wdata[5:4] == 2'b00) begin
        // Latch command keeps the first snapshot
        if (!m_held[c]) begin
          m_latch[c] = old_count;
        end
        m_held[c] = 1'b1;
      end else begin
        m_acc[c]      = req_wdata[5:4];
        m_mode[c]     = ((req_wdata[3:1] == 3'd2) || (req_wdata[3:1] == 3'd3)) ?
                        req_wdata[3:1] : 3'd0;
        m_init[c]     = 16'h0000;
        m_wr_msb[c]   = 1'b0;
        m_rd_msb[c]   = 1'b0;
        m_mode_set[c] = 1'b1;
      end
    end
    if (wr) begin
      if ((m_acc[c] == ACC_MSB) || ((m_acc[c] == ACC_BOTH) && m_wr_msb[c])) begin
        m_init[c][15:8] = req_wdata;
      end else begin
        m_init[c][7:0] = req_wdata;
      end
      // Final byte of the format starts the load
      m_load_req[c] = (m_acc[c] != ACC_BOTH) || m_wr_msb[c];
      if (m_acc[c] == ACC_BOTH) begin
        m_wr_msb[c] = ~m_wr_msb[c];
      end
    end
    if (rd) begin
      if ((m_acc[c] != ACC_BOTH) || m_rd_msb[c]) begin
        m_held[c] = 1'b0;
      end
      if (m_acc[c] == ACC_BOTH) begin
        m_rd_msb[c] = ~m_rd_msb[c];
      end
    end
  endtask

  // Advance the model over the coming WR_ edge
  task automatic step_model();
    logic [NUM_CH-1:0] wr_s;
    logic [NUM_CH-1:0] rd_s;
    logic [NUM_CH-1:0] ctrl_s;
    logic [15:0]       old_count;
    logic              fire;
    int                c;
    wr_s   = '0;
    rd_s   = '0;
    ctrl_s = '0;
    fire   = req_valid && !m_rsp_valid;
    if (fire) begin
      if (req_addr == ADDR_CTRL) begin
        if (req_write && (req_wdata[7:6] != 2'd3)) begin
          ctrl_s[req_wdata[7:6]] = 1'b1;
        end
      end else if (req_write) begin
        wr_s[req_addr] = 1'b1;
      end else begin
        rd_s[req_addr] = 1'b1;
      end
    end
    // Response data from the state before the edge
    if (fire && !req_write) begin
      m_rsp_valid = 1'b1;
      m_rsp_data  = (req_addr == ADDR_CTRL) ? 8'h00 : read_byte(req_addr);
    end else if (rsp_ready) begin
      m_rsp_valid = 1'b0;
    end
    for (c = 0; c < NUM_CH; c++) begin
      old_count = m_count[c];
      step_counter(c);
      step_regs(c, wr_s[c], rd_s[c], ctrl_s[c], old_count);
    end
  endtask

  task automatic compare_outputs();
    int c;
    for (c = 0; c < NUM_CH; c++) begin
      if (timer_out[c] !== m_out[c]) begin
        $display("Error: timer_out[%0d] expected %h actual %h at %0t",
                 c, m_out[c], timer_out[c], $time);
        error_count++;
      end
    end
    if (req_ready !== !m_rsp_valid) begin
      $display("Error: req_ready expected %h actual %h at %0t", !m_rsp_valid, req_ready, $time);
      error_count++;
    end
    if (rsp_valid !== m_rsp_valid) begin
      $display("Error: rsp_valid expected %h actual %h at %0t", m_rsp_valid, rsp_valid, $time);
      error_count++;
    end
    // Held data must stay put under back-pressure
    if (m_rsp_valid && (rsp_rdata !== m_rsp_data)) begin
      $display("Error: rsp_rdata expected %h actual %h at %0t", m_rsp_data, rsp_rdata, $time);
      error_count++;
    end
  endtask

  initial begin
    error_count = 0;
  end

  // Outputs settle before the falling edge and inputs hold until the next rise
  always @(negedge WR_) begin
    if (LOAD) begin
      reset_model();
    end else begin
      compare_outputs();
      step_model();
    end
  end

endmodule

/* tb/tb_pit_top.sv */
// Interval timer testbench with seeded random channel programming and tick and gate stimulus
`timescale 1ns/10ps

module tb_pit_top
  import pit_pkg::*;
();

  localparam int NUM_OPS    = 24;
  localparam int WAIT_LIMIT = 400;

  logic              WR_;
  logic              LOAD;
  logic              req_valid;
  logic              req_ready;
  logic              req_write;
  logic [1:0]        req_addr;
  logic [7:0]        req_wdata;
  logic              rsp_valid;
  logic              rsp_ready;
  logic [7:0]        rsp_rdata;
  logic [NUM_CH-1:0] tick;
  logic [NUM_CH-1:0] gate;
  logic [NUM_CH-1:0] timer_out;
  int                seed;
  int                timeouts;
  int                chk_errors;
  // Programming sequence drawn before the clock starts
  logic [1:0]        op_ch   [NUM_OPS];
  logic [1:0]        op_acc  [NUM_OPS];
  logic [2:0]        op_mode [NUM_OPS];
  logic [15:0]       op_cnt  [NUM_OPS];
  int                op_idle [NUM_OPS];

  pit_top i_dut (
    .WR_       (WR_),
    .LOAD      (LOAD),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req_write (req_write),
    .req_addr  (req_addr),
    .req_wdata (req_wdata),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp_rdata (rsp_rdata),
    .tick      (tick),
    .gate      (gate),
    .timer_out (timer_out)
  );

  pit_checker i_checker (
    .WR_         (WR_),
    .LOAD        (LOAD),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .req_write   (req_write),
    .req_addr    (req_addr),
    .req_wdata   (req_wdata),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp_rdata   (rsp_rdata),
    .tick        (tick),
    .gate        (gate),
    .timer_out   (timer_out),
    .error_count (chk_errors)
  );

  // 100 ns clock
  initial begin
    WR_ = 1'b0;
  end
  always #50 WR_ = ~WR_;

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic draw_ops();
    int i;
    int m;
    for (i = 0; i < NUM_OPS; i++) begin
      op_ch[i]   = 2'(rand_below(NUM_CH));
      m          = rand_below(3);
      op_mode[i] = (m == 0) ? 3'd0 : ((m == 1) ? 3'd2 : 3'd3);
      op_acc[i]  = 2'(1 + rand_below(3));
      // Even counts only for the square wave
      if (op_mode[i] == 3'd3) begin
        op_cnt[i] = 16'(4 + 2 * rand_below(19));
      end else begin
        op_cnt[i] = 16'(4 + rand_below(37));
      end
      op_idle[i] = 10 + rand_below(60);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(posedge WR_);
    #1;
  endtask

  // Entered 1 ns after a rising edge and left 1 ns after the accepting edge
  task automatic send_request(input logic wr, input logic [1:0] addr, input logic [7:0] data);
    int n;
    req_valid = 1'b1;
    req_write = wr;
    req_addr  = addr;
    req_wdata = data;
    n = 0;
    @(negedge WR_);
    while (!req_ready && (n < WAIT_LIMIT)) begin
      @(negedge WR_);
      n++;
    end
    if (!req_ready) begin
      $display("Timeout: request to address %0d not accepted within %0d cycles", addr, n);
      timeouts++;
    end
    @(posedge WR_);
    #1;
    req_valid = 1'b0;
  endtask

  task automatic wait_response();
    int n;
    n = 0;
    @(negedge WR_);
    while (!(rsp_valid && rsp_ready) && (n < WAIT_LIMIT)) begin
      @(negedge WR_);
      n++;
    end
    if (!(rsp_valid && rsp_ready)) begin
      $display("Timeout: read response not delivered within %0d cycles", n);
      timeouts++;
    end
    @(posedge WR_);
    #1;
  endtask

  task automatic run_op(input int i);
    int n_bytes;
    int k;
    n_bytes = (op_acc[i] == ACC_BOTH) ? 2 : 1;
    send_request(1'b1, ADDR_CTRL, {op_ch[i], op_acc[i], op_mode[i], 1'b0});
    // MSB-only access scales the count by 256
    send_request(1'b1, op_ch[i], op_cnt[i][7:0]);
    if (n_bytes == 2) begin
      send_request(1'b1, op_ch[i], op_cnt[i][15:8]);
    end
    idle_cycles(op_idle[i]);
    // Latch and let the counter run on before reading the frozen value
    send_request(1'b1, ADDR_CTRL, {op_ch[i], 6'b000000});
    idle_cycles(3);
    // A second latch while one is held keeps the first snapshot
    send_request(1'b1, ADDR_CTRL, {op_ch[i], 6'b000000});
    idle_cycles(2);
    for (k = 0; k < n_bytes; k++) begin
      send_request(1'b0, op_ch[i], 8'h00);
    end
    // Latch is released so the live count follows
    for (k = 0; k < n_bytes; k++) begin
      send_request(1'b0, op_ch[i], 8'h00);
    end
    wait_response();
  endtask

  // Per-cycle tick, gate and back-pressure
  initial begin
    int r;
    tick      = '0;
    gate      = '0;
    rsp_ready = 1'b1;
    forever begin
      @(posedge WR_);
      #1;
      r         = $random(seed);
      tick      = r[2:0];
      gate      = r[5:3] | r[8:6];
      rsp_ready = (r[10:9] != 2'b00);
    end
  end

  initial begin
    int i;
    seed      = 32'h9828;
    timeouts  = 0;
    LOAD      = 1'b1;
    req_valid = 1'b0;
    req_write = 1'b0;
    req_addr  = 2'd0;
    req_wdata = 8'h00;
    draw_ops();
    // Reset over 8 clocks
    repeat (8) @(posedge WR_);
    #1;
    LOAD = 1'b0;
    idle_cycles(2);
    for (i = 0; i < NUM_OPS; i++) begin
      run_op(i);
    end
    idle_cycles(20);
    $display("Summary: %0d checker errors, %0d timeouts", chk_errors, timeouts);
    if ((chk_errors == 0) && (timeouts == 0)) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* project.f */
hw/pit_pkg.sv
hw/pit_bus_port.sv
hw/pit_channel_regs.sv
hw/pit_channel_counter.sv
hw/pit_top.sv
tb/pit_checker.sv
tb/tb_pit_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the interval timer testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/10ps \
  -f project.f --top-module tb_pit_top -o sim_pit
./obj_dir/sim_pit | tee "$LOG"

if grep -q "Done: errors found" "$LOG"; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation PASSED"
